/* all.f */
verilog/tpu_cfg_pkg.sv
verilog/tpu_op_pkg.sv
verilog/lane_regfile.sv
verilog/bypass_buff.sv
verilog/lane_network.sv
verilog/lane_alu.sv
verilog/vec_unit_top.sv
+incdir+tb
tb/tb_vec_unit.sv

/* run.sh */
#!/bin/sh
# Compiles the vector slice testbench with Verilator and runs it.
# The log is searched for the pass line to decide the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_vec_unit \
	-Mdir obj_dir -o sim_vec_unit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_vec_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* tb/tb_ref_model.svh */
//////////////////////////////////////////////////////////////////////
// In-order model of the lane register files and the ALU rules.
// Included inside the testbench module after lane_vec_t is declared.
//////////////////////////////////////////////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

data_t mirror [NUM_LANES][NUM_REGS];				// Architectural state per lane

function automatic data_t pick_operand(int lane, index_t idx, path_e path, lane_id_t rot,
	data_t scalar);
	case (path)
		PATH_ROT:		return mirror[(lane + int'(rot)) % NUM_LANES][idx];
		PATH_SCALAR:	return scalar;
		default:		return mirror[lane][idx];
	endcase
endfunction

function automatic lane_vec_t expected_result(issue_t ins);
	lane_vec_t	res;
	data_t		a;
	data_t		b;
	data_t		c;
	for (int l = 0; l < NUM_LANES; l++) begin
		a = pick_operand(l, ins.src1, ins.path1, ins.rot, ins.scalar);
		b = pick_operand(l, ins.src2, ins.path2, ins.rot, ins.scalar);
		c = pick_operand(l, ins.src3, ins.path3, ins.rot, ins.scalar);
		case (ins.op)
			OP_ADD:		res[l] = a + b;
			OP_SUB:		res[l] = a - b;
			OP_MUL:		res[l] = a * b;				// Low word only
			OP_FMA:		res[l] = a * b + c;
			OP_AND:		res[l] = a & b;
			OP_XOR:		res[l] = a ^ b;
			default:	res[l] = a;
		endcase
	end
	return res;
endfunction

task automatic commit_result(input issue_t ins, input lane_vec_t res);
	for (int l = 0; l < NUM_LANES; l++) begin
		mirror[l][ins.dst] = res[l];
	end
endtask

task automatic clear_mirror();
	for (int l = 0; l < NUM_LANES; l++) begin
		for (int r = 0; r < NUM_REGS; r++) begin
			mirror[l][r] = '0;
		end
	end
endtask

`endif

/* tb/tb_vec_unit.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for vec_unit_top. Inputs change on the falling edge,
// results are compared on the falling edge two cycles after issue.
// Every write is lane-symmetric, so all lanes hold equal registers.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_vec_unit;

	import tpu_cfg_pkg::*;
	import tpu_op_pkg::*;

	localparam int NUM_LANES		= NUM_LANES_DEF;
	localparam int NUM_REGS			= NUM_REGS_DEF;
	localparam int RST_CYCLES		= 8;
	localparam int RAND_COUNT		= 300;
	localparam int DIRECTED_CYCLES	= 160;			// Directed tests and drains
	// Each random instruction takes at most two cycles
	localparam int MAX_CYCLES		= 2 * RST_CYCLES + DIRECTED_CYCLES + 2 * RAND_COUNT + 40;

	typedef data_t [NUM_LANES-1:0] lane_vec_t;

	logic			clock;
	logic			rst;
	logic			issue;
	issue_t			instr;
	logic			res_valid;
	lane_vec_t		res_data;

	int				seed;
	int				cycle;
	int				val_errs;
	int				proto_errs;

	lane_vec_t		exp_q [$];						// Expected vectors in issue order
	int				cyc_q [$];						// Issue cycle of each entry
	string			name_q [$];
	lane_vec_t		exp_v;
	int				exp_cyc;
	string			exp_name;

	`include "tb_ref_model.svh"

	vec_unit_top #(
		.NUM_LANES(		NUM_LANES	),
		.NUM_REGS(		NUM_REGS	),
		.BYPASS_DEPTH(	2			)
	) vec_unit_top_i (
		.clock(			clock		),
		.rst(			rst			),
		.issue(			issue		),
		.instr(			instr		),
		.res_valid(		res_valid	),
		.res_data(		res_data	)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout after %0d cycles with %0d results outstanding", cycle, exp_q.size());
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (res_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR: res_valid high at cycle %0d with nothing outstanding", cycle);
				proto_errs++;
			end
			else begin
				exp_v		= exp_q.pop_front();
				exp_cyc		= cyc_q.pop_front();
				exp_name	= name_q.pop_front();
				if (cycle != exp_cyc + 2) begin
					$display("ERROR: %s result came %0d cycles after issue", exp_name,
						cycle - exp_cyc);
					proto_errs++;
				end
				if (res_data != exp_v) begin
					$display("FAIL %s: expected %h actual %h", exp_name, exp_v, res_data);
					val_errs++;
				end
			end
		end
		else if ((exp_q.size() != 0) && (cyc_q[0] + 2 <= cycle)) begin
			$display("ERROR: %s issued at cycle %0d never raised res_valid", name_q[0], cyc_q[0]);
			proto_errs++;
			exp_v		= exp_q.pop_front();
			exp_cyc		= cyc_q.pop_front();
			exp_name	= name_q.pop_front();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////
	function automatic issue_t make_instr(op_e op, int dst, int s1, int s2, int s3,
		path_e p1, path_e p2, path_e p3, int rot, data_t scalar);
		issue_t	ins;
		ins.op		= op;
		ins.dst		= index_t'(dst);
		ins.src1	= index_t'(s1);
		ins.src2	= index_t'(s2);
		ins.src3	= index_t'(s3);
		ins.path1	= p1;
		ins.path2	= p2;
		ins.path3	= p3;
		ins.rot		= lane_id_t'(rot);
		ins.scalar	= scalar;
		return ins;
	endfunction

	function automatic issue_t random_instr();
		issue_t	ins;
		ins.op		= op_e'(3'({$random(seed)} % 7));
		ins.dst		= index_t'($random(seed));
		ins.src1	= index_t'($random(seed));
		ins.src2	= index_t'($random(seed));
		ins.src3	= index_t'($random(seed));
		ins.path1	= path_e'(2'({$random(seed)} % 3));
		ins.path2	= path_e'(2'({$random(seed)} % 3));
		ins.path3	= path_e'(2'({$random(seed)} % 3));
		ins.rot		= lane_id_t'($random(seed));
		ins.scalar	= $random(seed);
		return ins;
	endfunction

	// Drives one issue cycle and records the expected vector
	task automatic send(input issue_t ins, input string name);
		lane_vec_t	vec;
		vec = expected_result(ins);
		commit_result(ins, vec);
		exp_q.push_back(vec);
		cyc_q.push_back(cycle);
		name_q.push_back(name);
		issue	= 1'b1;
		instr	= ins;
		@(negedge clock);
		issue	= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clock);
		end
		idle(2);
	endtask

	task automatic apply_reset();
		rst		= 1'b1;
		issue	= 1'b0;
		repeat (RST_CYCLES) begin
			@(negedge clock);
			if (res_valid) begin
				$display("ERROR: res_valid high during reset at cycle %0d", cycle);
				proto_errs++;
			end
		end
		rst		= 1'b0;
		clear_mirror();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		path_e	p [3];
		seed		= 32'h6cdf_2e4c;
		cycle		= 0;
		val_errs	= 0;
		proto_errs	= 0;
		rst			= 1'b1;
		issue		= 1'b0;
		instr		= '0;
		apply_reset();

		// Load every register from the scalar, then each opcode on own reads
		for (int r = 0; r < NUM_REGS; r++) begin
			send(make_instr(OP_MOV, r, 0, 0, 0, PATH_SCALAR, PATH_OWN, PATH_OWN, 0,
				$random(seed)), "load");
		end
		for (int o = 0; o < 7; o++) begin
			send(make_instr(op_e'(3'(o)), 8 + o, 1, 2, 3, PATH_OWN, PATH_OWN, PATH_OWN, 0, '0),
				$sformatf("opcode %0d", o));
		end
		drain();

		for (int k = 0; k < NUM_LANES; k++) begin
			send(make_instr(OP_FMA, 12, 4, 5, 6, PATH_ROT, PATH_ROT, PATH_ROT, k, '0),
				$sformatf("rotate %0d", k));
		end
		drain();

		for (int k = 0; k < 3; k++) begin
			p[0]	= PATH_OWN;
			p[1]	= PATH_ROT;
			p[2]	= PATH_OWN;
			p[k]	= PATH_SCALAR;
			send(make_instr(OP_FMA, 10, 1, 2, 3, p[0], p[1], p[2], k + 1, $random(seed)),
				$sformatf("scalar fma %0d", k));
			send(make_instr(OP_SUB, 11, 4, 10, 6, p[2], p[0], p[1], k, $random(seed)),
				$sformatf("scalar sub %0d", k));
		end
		drain();

		// Dependent pairs with filler issues or idle cycles in between
		for (int mode = 0; mode < 2; mode++) begin
			for (int d = 1; d <= 3; d++) begin
				send(make_instr(OP_ADD, 6, 1, 2, 0, PATH_OWN, PATH_SCALAR, PATH_OWN, 0,
					$random(seed)), $sformatf("dep producer %0d", d));
				for (int f = 1; f < d; f++) begin
					if (mode == 0) begin
						send(make_instr(OP_XOR, 15, 3, 4, 0, PATH_OWN, PATH_OWN, PATH_OWN, 0,
							'0), "dep filler");
					end
					else begin
						idle(1);
					end
				end
				send(make_instr(OP_FMA, 7, 6, 6, 6, PATH_ROT, PATH_OWN, PATH_ROT, d, '0),
					$sformatf("dep consumer %0d mode %0d", d, mode));
			end
		end
		send(make_instr(OP_MOV, 9, 0, 0, 0, PATH_SCALAR, PATH_OWN, PATH_OWN, 0, $random(seed)),
			"dep first write");
		send(make_instr(OP_MOV, 9, 0, 0, 0, PATH_SCALAR, PATH_OWN, PATH_OWN, 0, $random(seed)),
			"dep second write");
		send(make_instr(OP_ADD, 8, 9, 9, 0, PATH_ROT, PATH_OWN, PATH_OWN, 3, '0), "dep youngest");
		drain();

		for (int n = 0; n < RAND_COUNT; n++) begin
			send(random_instr(), $sformatf("random %0d", n));
			if (({$random(seed)} % 4) == 0) begin
				idle(1);								// Gap between bursts
			end
		end
		drain();

		apply_reset();
		for (int r = 0; r < NUM_REGS; r++) begin
			send(make_instr(OP_ADD, r, r, r, 0, PATH_OWN, PATH_ROT, PATH_OWN, r, '0),
				$sformatf("after reset r%0d", r));
		end
		drain();

		$display("errors: value %0d, protocol %0d", val_errs, proto_errs);
		if ((val_errs == 0) && (proto_errs == 0)) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* verilog/vec_unit_top.sv */
//////////////////////////////////////////////////////////////////////
// Vector slice top: issue register and NUM_LANES lockstep lanes.
// No back-pressure; res_valid follows issue by exactly two cycles.
// NUM_REGS must equal 2**$bits(index_t) and NUM_LANES be at most 4.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_unit_top #(
	parameter int NUM_LANES		= tpu_cfg_pkg::NUM_LANES_DEF,
	parameter int NUM_REGS		= tpu_cfg_pkg::NUM_REGS_DEF,
	parameter int BYPASS_DEPTH	= 2
)(
	input	logic									clock,
	input	logic									rst,
	input	logic									issue,		// One-cycle strobe
	input	tpu_op_pkg::issue_t						instr,
	output	logic									res_valid,
	output	tpu_cfg_pkg::data_t [NUM_LANES-1:0]		res_data
);

	import tpu_cfg_pkg::*;
	import tpu_op_pkg::*;

	logic						valid_s1;
	issue_t						instr_s1;

	data_t [NUM_LANES-1:0]		lane_src1;			// Forwarded operands, all lanes
	data_t [NUM_LANES-1:0]		lane_src2;
	data_t [NUM_LANES-1:0]		lane_src3;

	wb_t						wb_lane [NUM_LANES];


	//////////////////////////////////////////////////////////////////////
	// Stage 1 register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			valid_s1	<= 1'b0;
		end
		else begin
			valid_s1	<= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			instr_s1	<= instr;
		end
	end


	//////////////////////////////////////////////////////////////////////
	// Lanes
	//////////////////////////////////////////////////////////////////////
	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		data_t		rf1;
		data_t		rf2;
		data_t		rf3;
		data_t		a;
		data_t		b;
		data_t		c;

		lane_regfile #(
			.NUM_REGS(		NUM_REGS		)
		) lane_regfile_i (
			.clock(			clock			),
			.rst(			rst				),
			.rd_idx1(		instr.src1		),		// Read at the issue edge
			.rd_idx2(		instr.src2		),
			.rd_idx3(		instr.src3		),
			.wb(			wb_lane[l]		),
			.rd_data1(		rf1				),
			.rd_data2(		rf2				),
			.rd_data3(		rf3				)
		);

		bypass_buff #(
			.BYPASS_DEPTH(	BYPASS_DEPTH	)
		) bypass_buff_i (
			.clock(			clock			),
			.rst(			rst				),
			.rd_idx1(		instr_s1.src1	),
			.rd_idx2(		instr_s1.src2	),
			.rd_idx3(		instr_s1.src3	),
			.rf_data1(		rf1				),
			.rf_data2(		rf2				),
			.rf_data3(		rf3				),
			.wb(			wb_lane[l]		),
			.src1(			lane_src1[l]	),
			.src2(			lane_src2[l]	),
			.src3(			lane_src3[l]	)
		);

		lane_network #(
			.NUM_LANES(		NUM_LANES		),
			.LANE_ID(		l				)
		) lane_network_i (
			.clock(			clock			),
			.valid(			valid_s1		),
			.instr(			instr_s1		),
			.lane_src1(		lane_src1		),
			.lane_src2(		lane_src2		),
			.lane_src3(		lane_src3		),
			.a(				a				),
			.b(				b				),
			.c(				c				)
		);

		lane_alu lane_alu_i (
			.clock(			clock			),
			.rst(			rst				),
			.valid(			valid_s1		),
			.op(			instr_s1.op		),
			.dst(			instr_s1.dst	),
			.a(				a				),
			.b(				b				),
			.c(				c				),
			.wb(			wb_lane[l]		)
		);

		assign res_data[l]	= wb_lane[l].data;
	end

	assign res_valid	= wb_lane[0].we;				// Lanes run in lockstep

	a_cfg_sizes: assert property (@(posedge clock)
		(NUM_REGS == 2**$bits(index_t)) && (NUM_LANES <= 2**$bits(lane_id_t)));

endmodule

/* verilog/lane_alu.sv */
//////////////////////////////////////////////////////////////////////
// Three-source ALU with a registered write-back.
// Products keep the low 32 bits, all arithmetic wraps.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lane_alu (
	input	logic					clock,
	input	logic					rst,
	input	logic					valid,		// Stage-1 valid
	input	tpu_op_pkg::op_e		op,
	input	tpu_cfg_pkg::index_t	dst,
	input	tpu_cfg_pkg::data_t		a,
	input	tpu_cfg_pkg::data_t		b,
	input	tpu_cfg_pkg::data_t		c,
	output	tpu_op_pkg::wb_t		wb			// Stage 2
);

	import tpu_cfg_pkg::*;
	import tpu_op_pkg::*;

	data_t						result;


	always_comb begin
		case (op)
			OP_ADD:		result = a + b;
			OP_SUB:		result = a - b;
			OP_MUL:		result = a * b;
			OP_FMA:		result = (a * b) + c;		// Both steps wrap
			OP_AND:		result = a & b;
			OP_XOR:		result = a ^ b;
			default:	result = a;					// OP_MOV
		endcase
	end

	always_ff @(posedge clock) begin
		wb.dst	<= dst;
		wb.data	<= result;
		if (rst) begin
			wb.we	<= 1'b0;
		end
		else begin
			wb.we	<= valid;
		end
	end

	a_op_legal: assert property (@(posedge clock) disable iff (rst)
		valid |-> (op inside {OP_ADD, OP_SUB, OP_MUL, OP_FMA, OP_AND, OP_XOR, OP_MOV}));

endmodule

/* verilog/lane_network.sv */
//////////////////////////////////////////////////////////////////////
// Picks each ALU source from own lane, a rotated lane or the scalar.
// Purely combinational in stage 1. NUM_LANES must not exceed 4.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lane_network #(
	parameter int NUM_LANES	= tpu_cfg_pkg::NUM_LANES_DEF,
	parameter int LANE_ID	= 0
)(
	input	logic									clock,		// Assertion sampling only
	input	logic									valid,		// Stage-1 valid
	input	tpu_op_pkg::issue_t						instr,		// Stage-1 instruction
	input	tpu_cfg_pkg::data_t [NUM_LANES-1:0]		lane_src1,	// Operand 1 of every lane
	input	tpu_cfg_pkg::data_t [NUM_LANES-1:0]		lane_src2,	// Operand 2 of every lane
	input	tpu_cfg_pkg::data_t [NUM_LANES-1:0]		lane_src3,	// Operand 3 of every lane
	output	tpu_cfg_pkg::data_t						a,
	output	tpu_cfg_pkg::data_t						b,
	output	tpu_cfg_pkg::data_t						c
);

	import tpu_cfg_pkg::*;
	import tpu_op_pkg::*;

	localparam int SEL_W	= (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [SEL_W-1:0]			rot_lane;			// Source lane for PATH_ROT

	data_t						own1;
	data_t						own2;
	data_t						own3;
	data_t						rot1;
	data_t						rot2;
	data_t						rot3;


	//////////////////////////////////////////////////////////////////////
	// Lane taps
	//////////////////////////////////////////////////////////////////////
	assign rot_lane	= SEL_W'((LANE_ID + int'(instr.rot)) % NUM_LANES);

	assign own1		= lane_src1[LANE_ID];
	assign own2		= lane_src2[LANE_ID];
	assign own3		= lane_src3[LANE_ID];

	assign rot1		= lane_src1[rot_lane];
	assign rot2		= lane_src2[rot_lane];
	assign rot3		= lane_src3[rot_lane];


	//////////////////////////////////////////////////////////////////////
	// Path select
	//////////////////////////////////////////////////////////////////////
	function automatic data_t pick(path_e path, data_t own, data_t rotd, data_t scalar);
		case (path)
			PATH_ROT:		return rotd;
			PATH_SCALAR:	return scalar;
			default:		return own;				// Illegal code falls back to own
		endcase
	endfunction

	assign a	= pick(instr.path1, own1, rot1, instr.scalar);
	assign b	= pick(instr.path2, own2, rot2, instr.scalar);
	assign c	= pick(instr.path3, own3, rot3, instr.scalar);

	a_path_legal: assert property (@(posedge clock)
		valid |-> ((instr.path1 != 2'd3) && (instr.path2 != 2'd3) && (instr.path3 != 2'd3)));

endmodule

/* verilog/bypass_buff.sv */
//////////////////////////////////////////////////////////////////////
// Forwards recent write-backs onto the three stage-1 operand reads.
// BYPASS_DEPTH must cover the register file read-before-write gap (2).
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bypass_buff #(
	parameter int BYPASS_DEPTH	= 2
)(
	input	logic					clock,
	input	logic					rst,
	input	tpu_cfg_pkg::index_t	rd_idx1,		// Stage-1 index
	input	tpu_cfg_pkg::index_t	rd_idx2,		// Stage-1 index
	input	tpu_cfg_pkg::index_t	rd_idx3,		// Stage-1 index
	input	tpu_cfg_pkg::data_t		rf_data1,		// Register file read
	input	tpu_cfg_pkg::data_t		rf_data2,
	input	tpu_cfg_pkg::data_t		rf_data3,
	input	tpu_op_pkg::wb_t		wb,				// Write-back being written now
	output	tpu_cfg_pkg::data_t		src1,			// Corrected operands
	output	tpu_cfg_pkg::data_t		src2,
	output	tpu_cfg_pkg::data_t		src3
);

	import tpu_cfg_pkg::*;

	index_t						hist_idx [BYPASS_DEPTH];	// Entry 0 is youngest
	data_t						hist_data [BYPASS_DEPTH];
	logic [BYPASS_DEPTH-1:0]	hist_vld;
	logic						wb_seen;					// Any write-back since reset


	//////////////////////////////////////////////////////////////////////
	// History of enabled write-backs
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (wb.we) begin
			hist_idx[0]		<= wb.dst;
			hist_data[0]	<= wb.data;
			for (int i = 1; i < BYPASS_DEPTH; i++) begin
				hist_idx[i]		<= hist_idx[i-1];
				hist_data[i]	<= hist_data[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			hist_vld	<= '0;
			wb_seen		<= 1'b0;
		end
		else if (wb.we) begin
			hist_vld	<= (hist_vld << 1) | BYPASS_DEPTH'(1);	// Shift in a valid entry
			wb_seen		<= 1'b1;
		end
	end


	//////////////////////////////////////////////////////////////////////
	// Forwarding
	//////////////////////////////////////////////////////////////////////
	function automatic data_t fwd(index_t idx, data_t rf);
		data_t	val;
		val = rf;
		// Oldest first so that younger matches override
		for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
			if (hist_vld[i] && (hist_idx[i] == idx)) begin
				val = hist_data[i];
			end
		end
		if (wb.we && (wb.dst == idx)) begin
			val = wb.data;						// Current write-back wins
		end
		return val;
	endfunction

	always_comb begin
		src1 = fwd(rd_idx1, rf_data1);
		src2 = fwd(rd_idx2, rf_data2);
		src3 = fwd(rd_idx3, rf_data3);
	end

	a_hist_empty: assert property (@(posedge clock) disable iff (rst)
		!wb_seen |-> (hist_vld == '0));

endmodule

/* verilog/lane_regfile.sv */
//////////////////////////////////////////////////////////////////////
// Lane register file, three registered reads and one write.
// A write is not seen by a read at the same edge. Reset zeroes all.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lane_regfile #(
	parameter int NUM_REGS	= tpu_cfg_pkg::NUM_REGS_DEF
)(
	input	logic					clock,
	input	logic					rst,
	input	tpu_cfg_pkg::index_t	rd_idx1,		// Issue-time index
	input	tpu_cfg_pkg::index_t	rd_idx2,		// Issue-time index
	input	tpu_cfg_pkg::index_t	rd_idx3,		// Issue-time index
	input	tpu_op_pkg::wb_t		wb,				// ALU write-back
	output	tpu_cfg_pkg::data_t		rd_data1,		// Valid in stage 1
	output	tpu_cfg_pkg::data_t		rd_data2,
	output	tpu_cfg_pkg::data_t		rd_data3
);

	import tpu_cfg_pkg::*;

	data_t						regs [NUM_REGS];


	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;				// Architectural zero state
			end
		end
		else if (wb.we) begin
			regs[wb.dst] <= wb.data;
		end
	end


	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////
	// Sampled every edge, the stage-1 valid tells whether the data is used
	always_ff @(posedge clock) begin
		rd_data1 <= regs[rd_idx1];			// Old value on a same-edge write
		rd_data2 <= regs[rd_idx2];
		rd_data3 <= regs[rd_idx3];
	end

endmodule

/* verilog/tpu_op_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Opcodes, operand path encodings, issue and write-back structs.
// Opcode 3'd7 and path 2'd3 are illegal and flagged by assertions.
//////////////////////////////////////////////////////////////////////

package tpu_op_pkg;

	import tpu_cfg_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		OP_ADD	= 3'd0,			// a + b
		OP_SUB	= 3'd1,			// a - b
		OP_MUL	= 3'd2,			// Low word of a * b
		OP_FMA	= 3'd3,			// a * b + c
		OP_AND	= 3'd4,			// a & b
		OP_XOR	= 3'd5,			// a ^ b
		OP_MOV	= 3'd6			// a
	} op_e;

	typedef enum logic [1:0] {
		PATH_OWN	= 2'd0,		// Own lane read
		PATH_ROT	= 2'd1,		// Read of lane (own + rot)
		PATH_SCALAR	= 2'd2		// Scalar broadcast
	} path_e;

	//////////////////////////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		op_e		op;
		index_t		src1;
		index_t		src2;
		index_t		src3;
		index_t		dst;
		path_e		path1;
		path_e		path2;
		path_e		path3;
		lane_id_t	rot;		// Rotation amount for PATH_ROT
		data_t		scalar;		// Broadcast to every lane
	} issue_t;

	typedef struct packed {
		logic		we;			// Write enable
		index_t		dst;
		data_t		data;
	} wb_t;

endpackage

/* verilog/tpu_cfg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Sizes and word types shared by every lane of the vector slice.
// index_t is sized for NUM_REGS_DEF and lane_id_t limits lanes to 4.
//////////////////////////////////////////////////////////////////////

package tpu_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Default sizes
	//////////////////////////////////////////////////////////////////////
	localparam int NUM_LANES_DEF	= 4;					// Lanes in lockstep
	localparam int NUM_REGS_DEF		= 16;					// Registers per lane

	localparam int DATA_W			= 32;					// Lane word width
	localparam int INDEX_W			= $clog2(NUM_REGS_DEF);	// Register index width
	localparam int LANE_ID_W		= 2;					// Rotation amount width

	//////////////////////////////////////////////////////////////////////
	// Word types
	//////////////////////////////////////////////////////////////////////
	// Unsigned lane word, arithmetic wraps at 2**32
	typedef logic [DATA_W-1:0]		data_t;

	typedef logic [INDEX_W-1:0]		index_t;				// Register number
	typedef logic [LANE_ID_W-1:0]	lane_id_t;				// Lane number

endpackage
